//--- include/cc_params.svh
// Widths, depths and fixed addresses of the core data path
// Shared by the package and the RTL

`ifndef CC_PARAMS_SVH
`define CC_PARAMS_SVH

// Bus widths
`define CC_ADDR_W 32
`define CC_DATA_W 32
`define CC_STRB_W 4

// User field, carries the collective mask
`define CC_USER_W 8

// TCDM window is 4 KiB
`define CC_TCDM_ADDR_W 12
`define CC_TCDM_ALIAS_START 32'h1000_0000

// Demux order queue depth
`define CC_RESP_DEPTH 4
// Outstanding TCDM requests, also the response buffer depth
`define CC_BUF_DEPTH 4

`endif

//--- design/cc_data_pkg.sv
// Request and response payload types of the core data path
// Channel structs, TCDM structs and the port select enum

`include "cc_params.svh"

package cc_data_pkg;

  // --------------------
  // Payloads
  // --------------------
  typedef struct packed {
    logic [`CC_ADDR_W-1:0] addr;
    logic                  write;
    logic [`CC_DATA_W-1:0] data;
    logic [`CC_STRB_W-1:0] strb;
    logic [`CC_USER_W-1:0] user;
  } cc_dreq_t;

  typedef struct packed {
    logic [`CC_DATA_W-1:0] data;
    logic                  error;
  } cc_drsp_t;

  // --------------------
  // Channels
  // --------------------
  // Driven by the requester
  typedef struct packed {
    cc_dreq_t q;
    logic     q_valid;
    logic     p_ready;
  } cc_req_chan_t;

  // Driven by the responder
  typedef struct packed {
    cc_drsp_t p;
    logic     p_valid;
    logic     q_ready;
  } cc_rsp_chan_t;

  // TCDM side, fixed one-cycle response latency
  typedef struct packed {
    logic [`CC_TCDM_ADDR_W-1:0] addr;
    logic                       write;
    logic [`CC_DATA_W-1:0]      data;
    logic [`CC_STRB_W-1:0]      strb;
    logic                       q_valid;
  } cc_tcdm_req_t;

  typedef struct packed {
    logic                  q_ready;
    logic                  p_valid;
    logic [`CC_DATA_W-1:0] data;
  } cc_tcdm_rsp_t;

  typedef enum logic {
    SEL_SOC  = 1'b0,
    SEL_TCDM = 1'b1
  } cc_sel_e;

endpackage

//--- design/cc_spill_reg.sv
// Two-entry valid/ready register cut
// Payload type set by parameter

`timescale 1ns/1ps

module cc_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Input side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // Output side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes new data, slot B keeps what the sink refused
  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // --------------------
  // Slot control
  // --------------------
  assign a_fill  = valid_i && ready_o;
  // A empties whenever B is free, either to the sink or into B
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  // B always holds the older entry
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = !a_full_q || !b_full_q;

endmodule

//--- design/cc_addr_route.sv
// Address decode for the data path
// TCDM base window, fixed alias window, collective reroute

`timescale 1ns/1ps
`include "cc_params.svh"

module cc_addr_route (
  input  cc_data_pkg::cc_dreq_t   req_i,
  input  logic [`CC_ADDR_W-1:0]   tcdm_addr_base_i,
  output cc_data_pkg::cc_sel_e    sel_o
);

  import cc_data_pkg::*;

  // NAPOT mask, keeps the bits above the window offset
  localparam logic [`CC_ADDR_W-1:0] win_mask = {`CC_ADDR_W{1'b1}} << `CC_TCDM_ADDR_W;
  localparam logic [`CC_ADDR_W-1:0] alias_base = `CC_TCDM_ALIAS_START;

  logic [`CC_ADDR_W-1:0] addr_tag;
  logic                  hit_base;
  logic                  hit_alias;
  logic                  tcdm_hit;
  logic                  is_collective;

  // --------------------
  // Window match
  // --------------------
  assign addr_tag  = req_i.addr & win_mask;
  assign hit_base  = (addr_tag == (tcdm_addr_base_i & win_mask));
  // Alias is always enabled
  assign hit_alias = (addr_tag == (alias_base & win_mask));
  assign tcdm_hit  = hit_base || hit_alias;

  // --------------------
  // Collective reroute
  // --------------------
  // Nonzero collective mask in the user field
  assign is_collective = (req_i.user != '0);

  // Collectives are resolved in the SoC interconnect, which loops them
  // back to the TCDM from outside the cluster
  always_comb begin
    if (tcdm_hit && !is_collective) begin
      sel_o = SEL_TCDM;
    end else begin
      sel_o = SEL_SOC;
    end
  end

endmodule

//--- design/cc_reqrsp_demux.sv
// Request demux between the SoC and TCDM ports
// In-order response return through a select queue

`timescale 1ns/1ps
`include "cc_params.svh"

module cc_reqrsp_demux (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  cc_data_pkg::cc_sel_e      sel_i,
  // Upstream
  input  cc_data_pkg::cc_req_chan_t req_i,
  output cc_data_pkg::cc_rsp_chan_t rsp_o,
  // SoC port
  output cc_data_pkg::cc_req_chan_t soc_req_o,
  input  cc_data_pkg::cc_rsp_chan_t soc_rsp_i,
  // TCDM port
  output cc_data_pkg::cc_req_chan_t tcdm_req_o,
  input  cc_data_pkg::cc_rsp_chan_t tcdm_rsp_i
);

  import cc_data_pkg::*;

  // Depth is a power of two, pointers wrap naturally
  localparam int unsigned depth = `CC_RESP_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam logic [ptr_w:0] full_count = depth[ptr_w:0];

  // Port of each request still waiting for its response
  cc_sel_e          order_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   count_q;

  logic    queue_full;
  logic    queue_empty;
  cc_sel_e head_sel;
  logic    sel_ready;
  logic    push;
  logic    pop;

  assign queue_full  = (count_q == full_count);
  assign queue_empty = (count_q == '0);
  assign head_sel    = order_q[rd_ptr_q];

  // --------------------
  // Request path
  // --------------------
  assign sel_ready = (sel_i == SEL_TCDM) ? tcdm_rsp_i.q_ready : soc_rsp_i.q_ready;

  always_comb begin
    soc_req_o.q        = req_i.q;
    soc_req_o.q_valid  = req_i.q_valid && !queue_full && (sel_i == SEL_SOC);
    soc_req_o.p_ready  = req_i.p_ready && !queue_empty && (head_sel == SEL_SOC);
    tcdm_req_o.q       = req_i.q;
    tcdm_req_o.q_valid = req_i.q_valid && !queue_full && (sel_i == SEL_TCDM);
    tcdm_req_o.p_ready = req_i.p_ready && !queue_empty && (head_sel == SEL_TCDM);
  end

  // --------------------
  // Response path
  // --------------------
  // Only the port at the queue head may answer
  always_comb begin
    rsp_o.q_ready = sel_ready && !queue_full;
    if (head_sel == SEL_TCDM) begin
      rsp_o.p       = tcdm_rsp_i.p;
      rsp_o.p_valid = tcdm_rsp_i.p_valid && !queue_empty;
    end else begin
      rsp_o.p       = soc_rsp_i.p;
      rsp_o.p_valid = soc_rsp_i.p_valid && !queue_empty;
    end
  end

  assign push = req_i.q_valid && rsp_o.q_ready;
  assign pop  = rsp_o.p_valid && req_i.p_ready;

  // --------------------
  // Order queue
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= sel_i;
    end
  end

endmodule

//--- design/cc_tcdm_adapter.sv
// Request/response channel to TCDM protocol conversion
// Credit-limited issue and fall-through response buffer

`timescale 1ns/1ps
`include "cc_params.svh"

module cc_tcdm_adapter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  cc_data_pkg::cc_req_chan_t req_i,
  output cc_data_pkg::cc_rsp_chan_t rsp_o,
  output cc_data_pkg::cc_tcdm_req_t tcdm_req_o,
  input  cc_data_pkg::cc_tcdm_rsp_t tcdm_rsp_i
);

  import cc_data_pkg::*;

  // Power of two depth, pointers wrap naturally
  localparam int unsigned depth = `CC_BUF_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam logic [ptr_w:0] full_count = depth[ptr_w:0];

  // In-flight plus buffered responses
  logic [ptr_w:0] credit_q;
  logic           can_issue;
  logic           issue;

  logic [`CC_DATA_W-1:0] buf_q [depth];
  logic [ptr_w-1:0]      wr_ptr_q;
  logic [ptr_w-1:0]      rd_ptr_q;
  logic [ptr_w:0]        buf_cnt_q;
  logic                  buf_empty;
  logic                  buf_push;
  logic                  buf_pop;
  logic                  rsp_pop;
  cc_drsp_t              rsp_head;

  // --------------------
  // Request issue
  // --------------------
  assign can_issue = (credit_q != full_count);
  assign issue     = tcdm_req_o.q_valid && tcdm_rsp_i.q_ready;

  always_comb begin
    tcdm_req_o.addr    = req_i.q.addr[`CC_TCDM_ADDR_W-1:0];
    tcdm_req_o.write   = req_i.q.write;
    tcdm_req_o.data    = req_i.q.data;
    tcdm_req_o.strb    = req_i.q.strb;
    tcdm_req_o.q_valid = req_i.q_valid && can_issue;
  end

  // --------------------
  // Response buffer
  // --------------------
  assign buf_empty = (buf_cnt_q == '0);
  // Bypass the buffer when empty and the consumer takes it right away
  assign buf_push  = tcdm_rsp_i.p_valid && !(buf_empty && req_i.p_ready);
  assign buf_pop   = !buf_empty && req_i.p_ready;

  always_comb begin
    rsp_head.data  = buf_empty ? tcdm_rsp_i.data : buf_q[rd_ptr_q];
    rsp_head.error = 1'b0;
  end

  always_comb begin
    rsp_o.p       = rsp_head;
    rsp_o.p_valid = !buf_empty || tcdm_rsp_i.p_valid;
    rsp_o.q_ready = tcdm_rsp_i.q_ready && can_issue;
  end

  assign rsp_pop = rsp_o.p_valid && req_i.p_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q  <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      buf_cnt_q <= '0;
    end else begin
      if (issue && !rsp_pop) begin
        credit_q <= credit_q + 1'b1;
      end else if (rsp_pop && !issue) begin
        credit_q <= credit_q - 1'b1;
      end
      if (buf_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (buf_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (buf_push && !buf_pop) begin
        buf_cnt_q <= buf_cnt_q + 1'b1;
      end else if (buf_pop && !buf_push) begin
        buf_cnt_q <= buf_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_push) begin
      buf_q[wr_ptr_q] <= tcdm_rsp_i.data;
    end
  end

endmodule

//--- design/cc_data_path.sv
// Core data path top level
// Request cut, address route, port demux, TCDM adapter, response cut

`timescale 1ns/1ps
`include "cc_params.svh"

module cc_data_path (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Core side
  input  cc_data_pkg::cc_req_chan_t core_req_i,
  output cc_data_pkg::cc_rsp_chan_t core_rsp_o,
  // SoC port
  output cc_data_pkg::cc_req_chan_t data_req_o,
  input  cc_data_pkg::cc_rsp_chan_t data_rsp_i,
  // TCDM port
  output cc_data_pkg::cc_tcdm_req_t tcdm_req_o,
  input  cc_data_pkg::cc_tcdm_rsp_t tcdm_rsp_i,
  input  logic [`CC_ADDR_W-1:0]     tcdm_addr_base_i
);

  import cc_data_pkg::*;

  // Request cut output
  cc_dreq_t     cut_req;
  logic         cut_req_valid;
  logic         req_cut_ready;
  cc_sel_e      sel;
  // Demux upstream and TCDM branch
  cc_req_chan_t demux_req;
  cc_rsp_chan_t demux_rsp;
  cc_req_chan_t tcdm_chan_req;
  cc_rsp_chan_t tcdm_chan_rsp;
  // Response cut output
  logic         rsp_cut_ready;
  logic         rsp_cut_valid;
  cc_drsp_t     rsp_cut_data;

  // --------------------
  // Request path
  // --------------------
  cc_spill_reg #(
    .T (cc_dreq_t)
  ) i_req_cut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (core_req_i.q_valid),
    .ready_o (req_cut_ready),
    .data_i  (core_req_i.q),
    .valid_o (cut_req_valid),
    .ready_i (demux_rsp.q_ready),
    .data_o  (cut_req)
  );

  cc_addr_route i_addr_route (
    .req_i            (cut_req),
    .tcdm_addr_base_i (tcdm_addr_base_i),
    .sel_o            (sel)
  );

  assign demux_req = '{q: cut_req, q_valid: cut_req_valid, p_ready: rsp_cut_ready};

  cc_reqrsp_demux i_demux (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sel_i      (sel),
    .req_i      (demux_req),
    .rsp_o      (demux_rsp),
    .soc_req_o  (data_req_o),
    .soc_rsp_i  (data_rsp_i),
    .tcdm_req_o (tcdm_chan_req),
    .tcdm_rsp_i (tcdm_chan_rsp)
  );

  cc_tcdm_adapter i_tcdm_adapter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (tcdm_chan_req),
    .rsp_o      (tcdm_chan_rsp),
    .tcdm_req_o (tcdm_req_o),
    .tcdm_rsp_i (tcdm_rsp_i)
  );

  // --------------------
  // Response path
  // --------------------
  cc_spill_reg #(
    .T (cc_drsp_t)
  ) i_rsp_cut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (demux_rsp.p_valid),
    .ready_o (rsp_cut_ready),
    .data_i  (demux_rsp.p),
    .valid_o (rsp_cut_valid),
    .ready_i (core_req_i.p_ready),
    .data_o  (rsp_cut_data)
  );

  assign core_rsp_o = '{p: rsp_cut_data, p_valid: rsp_cut_valid, q_ready: req_cut_ready};

endmodule

//--- verification/cc_data_path_tb.sv
// Testbench for the core data path
// LFSR stimulus, SoC and TCDM models, in-order response scoreboard

`timescale 1ns/1ps
`include "cc_params.svh"

module cc_data_path_tb;

  import cc_data_pkg::*;

  localparam int num_req        = 200;
  localparam int timeout_cycles = num_req * 20;
  localparam int drain_cycles   = 20;
  localparam int mem_words      = 1 << (`CC_TCDM_ADDR_W - 2);
  localparam logic [31:0]           lfsr_taps   = 32'h8020_0003;
  localparam logic [`CC_ADDR_W-1:0] tcdm_base   = 32'h8000_0000;
  localparam logic [`CC_ADDR_W-1:0] alias_base  = `CC_TCDM_ALIAS_START;
  localparam logic [`CC_DATA_W-1:0] soc_pattern = 32'h5a5a_5a5a;

  // What the core should see for one accepted request
  typedef struct packed {
    logic                  to_tcdm;
    logic                  write;
    logic [`CC_DATA_W-1:0] data;
  } exp_rsp_t;

  logic         clk_i;
  logic         rst_ni;
  cc_req_chan_t core_req;
  cc_rsp_chan_t core_rsp;
  cc_req_chan_t data_req;
  cc_rsp_chan_t data_rsp;
  cc_tcdm_req_t tcdm_req;
  cc_tcdm_rsp_t tcdm_rsp;

  logic [31:0]           lfsr_q;
  logic [`CC_DATA_W-1:0] tcdm_mem   [mem_words];
  logic [`CC_DATA_W-1:0] shadow_mem [mem_words];
  cc_dreq_t              soc_exp  [$];
  cc_dreq_t              tcdm_exp [$];
  exp_rsp_t              rsp_exp  [$];
  logic [`CC_DATA_W-1:0] soc_q    [$];

  // Per-cycle state shared by sampling and driving
  logic                  req_taken;
  logic                  soc_taken;
  int unsigned           soc_wait;
  logic                  tcdm_answer;
  logic [`CC_DATA_W-1:0] tcdm_answer_data;
  logic                  stall_q;
  cc_drsp_t              held_p;
  int                    sent;
  int                    acc_cnt;
  int                    rsp_cnt;
  int                    coll_cnt;
  int                    stall_cnt;
  int                    cycle_cnt;

  cc_data_path cc_data_path_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_req_i       (core_req),
    .core_rsp_o       (core_rsp),
    .data_req_o       (data_req),
    .data_rsp_i       (data_rsp),
    .tcdm_req_o       (tcdm_req),
    .tcdm_rsp_i       (tcdm_rsp),
    .tcdm_addr_base_i (tcdm_base)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [95:0] exp_val,
                             input logic [95:0] act_val);
    assert (exp_val === act_val) else begin
      fail_run($sformatf("Fail %s: expected %0h, actual %0h", name, exp_val, act_val));
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned k = 0; k < n; k++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ lfsr_taps) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic logic [31:0] fill_word(input int unsigned i);
    logic [31:0] w;
    w = i;
    return (w * 32'h9e37_79b9) ^ 32'ha5c3_0f1e;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  strb);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < `CC_STRB_W; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return word;
  endfunction

  function automatic logic in_tcdm_window(input logic [`CC_ADDR_W-1:0] addr);
    logic [`CC_ADDR_W-1:0] tag;
    tag = addr >> `CC_TCDM_ADDR_W;
    return (tag == (tcdm_base >> `CC_TCDM_ADDR_W)) || (tag == (alias_base >> `CC_TCDM_ADDR_W));
  endfunction

  task automatic check_idle_outputs();
    check_value("reset soc q_valid", '0, data_req.q_valid);
    check_value("reset soc p_ready", '0, data_req.p_ready);
    check_value("reset tcdm q_valid", '0, tcdm_req.q_valid);
    check_value("reset core p_valid", '0, core_rsp.p_valid);
  endtask

  task automatic new_request();
    logic [31:0] r;
    r = take_bits(2);
    case (r[1:0])
      2'd0:    core_req.q.addr = tcdm_base;
      2'd1:    core_req.q.addr = alias_base;
      default: core_req.q.addr = 32'h4000_0000;
    endcase
    r = take_bits(`CC_TCDM_ADDR_W - 2);
    core_req.q.addr[`CC_TCDM_ADDR_W-1:2] = r[`CC_TCDM_ADDR_W-3:0];
    r = take_bits(5);
    // About a quarter carry a collective mask
    core_req.q.user  = (r[4:3] == 2'b11) ? (8'h01 << r[2:0]) : 8'h00;
    r = take_bits(1);
    core_req.q.write = r[0];
    core_req.q.data  = take_bits(`CC_DATA_W);
    r = take_bits(`CC_STRB_W);
    core_req.q.strb  = r[`CC_STRB_W-1:0];
    core_req.q_valid = 1'b1;
  endtask

  // --------------------
  // Sampling at the clock edge
  // --------------------
  task automatic sample_cycle();
    cc_dreq_t                  req;
    exp_rsp_t                  exp_r;
    logic [`CC_TCDM_ADDR_W-3:0] idx;
    logic                      grant;
    if (stall_q) begin
      assert (core_rsp.p_valid) else fail_run("core response valid dropped while stalled");
      check_value("stalled response payload", held_p, core_rsp.p);
    end
    if (core_rsp.p_valid && core_req.p_ready) begin
      assert (rsp_exp.size() != 0) else fail_run("core response with no request outstanding");
      exp_r = rsp_exp.pop_front();
      check_value("response error", '0, core_rsp.p.error);
      if (!exp_r.write) begin
        check_value(exp_r.to_tcdm ? "tcdm read data" : "soc read data", exp_r.data,
                    core_rsp.p.data);
      end
      rsp_cnt++;
    end
    if (data_req.q_valid && data_rsp.q_ready) begin
      assert (soc_exp.size() != 0) else fail_run("SoC port got a request that was not expected");
      req = soc_exp.pop_front();
      check_value("soc request", req, data_req.q);
      soc_q.push_back(data_req.q.addr ^ soc_pattern);
    end
    if (data_rsp.p_valid && data_req.p_ready) begin
      void'(soc_q.pop_front());
      soc_taken = 1'b1;
      soc_wait  = take_bits(2);
    end
    grant = tcdm_req.q_valid && tcdm_rsp.q_ready;
    if (grant) begin
      assert (tcdm_exp.size() != 0) else fail_run("TCDM port got a request that was not expected");
      req = tcdm_exp.pop_front();
      check_value("tcdm request", {req.addr[`CC_TCDM_ADDR_W-1:0], req.write, req.data, req.strb},
                  {tcdm_req.addr, tcdm_req.write, tcdm_req.data, tcdm_req.strb});
      idx = tcdm_req.addr[`CC_TCDM_ADDR_W-1:2];
      tcdm_answer_data = tcdm_mem[idx];
      if (tcdm_req.write) begin
        tcdm_mem[idx] = merge_bytes(tcdm_mem[idx], tcdm_req.data, tcdm_req.strb);
      end
    end
    tcdm_answer = grant;
    // Expected route and response of an accepted core request
    if (core_req.q_valid && core_rsp.q_ready) begin
      req           = core_req.q;
      exp_r.write   = req.write;
      exp_r.to_tcdm = in_tcdm_window(req.addr) && (req.user == '0);
      if (exp_r.to_tcdm) begin
        idx        = req.addr[`CC_TCDM_ADDR_W-1:2];
        exp_r.data = shadow_mem[idx];
        if (req.write) begin
          shadow_mem[idx] = merge_bytes(shadow_mem[idx], req.data, req.strb);
        end
        tcdm_exp.push_back(req);
      end else begin
        exp_r.data = req.addr ^ soc_pattern;
        soc_exp.push_back(req);
      end
      if (in_tcdm_window(req.addr) && (req.user != '0)) begin
        coll_cnt++;
      end
      rsp_exp.push_back(exp_r);
      acc_cnt++;
      req_taken = 1'b1;
    end
    stall_q = core_rsp.p_valid && !core_req.p_ready;
    held_p  = core_rsp.p;
    if (stall_q) begin
      stall_cnt++;
    end
  endtask

  // --------------------
  // Driving after the edge
  // --------------------
  task automatic drive_cycle();
    logic [31:0] r;
    tcdm_rsp.p_valid = tcdm_answer;
    tcdm_rsp.data    = tcdm_answer ? tcdm_answer_data : '0;
    r = take_bits(2);
    tcdm_rsp.q_ready = (r[1:0] != 2'b00);
    r = take_bits(2);
    data_rsp.q_ready = (r[1:0] != 2'b00);
    r = take_bits(1);
    core_req.p_ready = r[0];
    // SoC answers in order after a random wait
    if (soc_taken || !data_rsp.p_valid) begin
      data_rsp.p_valid = 1'b0;
      if (soc_wait != 0) begin
        soc_wait--;
      end else if (soc_q.size() != 0) begin
        data_rsp.p_valid = 1'b1;
        data_rsp.p.data  = soc_q[0];
        data_rsp.p.error = 1'b0;
      end
    end
    soc_taken = 1'b0;
    if (req_taken || !core_req.q_valid) begin
      req_taken = 1'b0;
      if (sent < num_req) begin
        new_request();
        sent++;
      end else begin
        core_req.q_valid = 1'b0;
      end
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_cycles) begin
      fail_run("timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    lfsr_q   = 32'he760;
    rst_ni   = 1'b0;
    core_req = '0;
    data_rsp = '0;
    tcdm_rsp = '0;
    {req_taken, soc_taken, tcdm_answer, stall_q} = '0;
    tcdm_answer_data = '0;
    held_p    = '0;
    soc_wait  = 0;
    sent      = 0;
    acc_cnt   = 0;
    rsp_cnt   = 0;
    coll_cnt  = 0;
    stall_cnt = 0;
    cycle_cnt = 0;
    for (int i = 0; i < mem_words; i++) begin
      tcdm_mem[i]   = fill_word(i);
      shadow_mem[i] = fill_word(i);
    end
    repeat (3) begin
      @(posedge clk_i);
      check_idle_outputs();
    end
    #1 rst_ni = 1'b1;
    // First cycle out of reset
    @(posedge clk_i);
    check_idle_outputs();
    #1;
    drive_cycle();
    while (acc_cnt < num_req || rsp_exp.size() != 0) begin
      @(posedge clk_i);
      sample_cycle();
      #1;
      drive_cycle();
    end
    // Idle tail, any late response or port request is an extra one
    repeat (drain_cycles) begin
      @(posedge clk_i);
      sample_cycle();
      #1;
      drive_cycle();
    end
    if (soc_exp.size() == 0 && tcdm_exp.size() == 0 && coll_cnt != 0 && stall_cnt != 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_run($sformatf("end of run: %0d responses for %0d requests, %0d collectives, %0d stalls",
                         rsp_cnt, acc_cnt, coll_cnt, stall_cnt));
    end
  end

endmodule

//--- vlog.f
+incdir+include
design/cc_data_pkg.sv
design/cc_spill_reg.sv
design/cc_addr_route.sv
design/cc_reqrsp_demux.sv
design/cc_tcdm_adapter.sv
design/cc_data_path.sv
verification/cc_data_path_tb.sv

//--- Makefile
# Verilator build and run of the core data path testbench

TOP := cc_data_path_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

# Passes only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir
